// File: src/cnn_geom_pkg.sv
// geometry package: element and beat widths, buffer word, address and count types
package cnn_geom_pkg;

	localparam int DATA_WIDTH     = 8;  // one pixel or weight element
	localparam int COLUMN_NUM     = 6;  // weight memory columns
	localparam int BEAT_WIDTH     = 16; // DMA word
	localparam int BEATS_PER_WORD = 3;

	localparam int WORD_WIDTH = DATA_WIDTH * COLUMN_NUM;

	typedef logic [BEAT_WIDTH-1:0] beat_t;

	// one image word or one weight row, beat 0 in the low bits
	typedef logic [WORD_WIDTH-1:0] buf_word_t;

	typedef logic [11:0] dma_addr_t;
	typedef logic [9:0]  imem_addr_t; // 1024 image words
	typedef logic [6:0]  wmem_addr_t; // rows per weight bank

	typedef logic [COLUMN_NUM-1:0] col_mask_t; // one-hot column write enable

	typedef logic [7:0] wgt_count_t;

endpackage

// File: src/cnn_ctrl_pkg.sv
// control package: load states, kernel modes and the last weight column per mode
package cnn_ctrl_pkg;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_IMAGE,  // image words into the image buffer
		LD_WEIGHT, // weight rows into the ping-pong banks
		LD_DRAIN   // wait for the consumer to free both banks
	} load_state_t;

	typedef enum logic [1:0] {
		MODE_3X3_QUAD = 2'b00,
		MODE_4X4      = 2'b01,
		MODE_5X5      = 2'b10,
		MODE_6X6      = 2'b11
	} kernel_mode_t;

	// one-hot of the column that ends a weight row
	function automatic cnn_geom_pkg::col_mask_t last_column(input kernel_mode_t mode);
		case (mode)
			MODE_4X4: last_column = cnn_geom_pkg::col_mask_t'(1) << 3;
			MODE_5X5: last_column = cnn_geom_pkg::col_mask_t'(1) << 4;
			default:  last_column = cnn_geom_pkg::col_mask_t'(1) << 5; // quad 3x3 uses all six
		endcase
	endfunction

endpackage

// File: src/beat_packer.sv
// beat packer: collects three DMA beats into one buffer word
module beat_packer (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_beat_vld,
	input  cnn_geom_pkg::beat_t     i_beat,
	output logic                    o_word_vld,
	output cnn_geom_pkg::buf_word_t o_word
);
	import cnn_geom_pkg::*;

	localparam int HELD_BITS = (BEATS_PER_WORD - 1) * BEAT_WIDTH;

	logic [1:0]           phase;
	logic [HELD_BITS-1:0] held; // earlier beats, oldest at the bottom
	logic                 last_beat;

	assign last_beat = i_beat_vld && (phase == 2'(BEATS_PER_WORD - 1));

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			phase      <= 2'd0;
			o_word_vld <= 1'b0;
		end else begin
			o_word_vld <= last_beat;
			if (last_beat)
				phase <= 2'd0;
			else if (i_beat_vld)
				phase <= phase + 2'd1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (last_beat)
			o_word <= {i_beat, held};
		else if (i_beat_vld)
			held <= {i_beat, held[HELD_BITS-1:BEAT_WIDTH]};
	end

	a_phase_range: assert property (@(posedge i_clk) disable iff (!i_rst)
		phase <= 2'(BEATS_PER_WORD - 1));

endmodule

// File: src/load_sequencer.sv
// load sequencer: DMA read issue, image and weight buffer writes, bank close and done
module load_sequencer #(
	parameter int BANK_ROWS = 128
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_start,
	input  cnn_ctrl_pkg::kernel_mode_t i_mode,
	input  cnn_geom_pkg::imem_addr_t   i_img_words,
	input  cnn_geom_pkg::wgt_count_t   i_wgt_rows,
	input  cnn_geom_pkg::dma_addr_t    i_img_base,
	input  cnn_geom_pkg::dma_addr_t    i_wgt_base,
	input  cnn_geom_pkg::beat_t        i_dma_rd_data,
	input  logic                       i_can_fill,
	input  logic                       i_drained,
	output logic                       o_dma_rd_en,
	output cnn_geom_pkg::dma_addr_t    o_dma_rd_addr,
	output logic                       o_img_wr_en,
	output cnn_geom_pkg::imem_addr_t   o_img_wr_addr,
	output cnn_geom_pkg::buf_word_t    o_img_wr_data,
	output cnn_geom_pkg::col_mask_t    o_wmem_wr_en,
	output cnn_geom_pkg::wmem_addr_t   o_wmem_wr_addr,
	output cnn_geom_pkg::buf_word_t    o_wmem_wr_data,
	output logic                       o_bank_filled,
	output cnn_geom_pkg::wgt_count_t   o_fill_rows,
	output logic                       o_done
);
	import cnn_geom_pkg::*;
	import cnn_ctrl_pkg::*;

	load_state_t state;
	logic [1:0]  rd_beat;      // beat within the word being read
	imem_addr_t  rd_words;
	col_mask_t   rd_col;
	wgt_count_t  rd_rows;
	wgt_count_t  rd_bank_rows;
	logic        closing;      // bank fully read, its last write still in flight
	logic        beat_vld;
	logic        word_vld;
	buf_word_t   word;
	imem_addr_t  wr_words;
	col_mask_t   wr_col;
	wmem_addr_t  wr_addr;
	wgt_count_t  wr_rows;
	col_mask_t   last_col;
	logic        word_end;
	logic        row_end;
	logic        img_sel;
	logic        wr_row_end;

	assign last_col = last_column(i_mode);
	assign word_end = o_dma_rd_en && (rd_beat == 2'(BEATS_PER_WORD - 1));
	assign row_end  = word_end && (rd_col == last_col);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state         <= LD_IDLE;
			o_dma_rd_en   <= 1'b0;
			o_dma_rd_addr <= '0;
			rd_beat       <= 2'd0;
			rd_words      <= '0;
			rd_col        <= col_mask_t'(1);
			rd_rows       <= '0;
			rd_bank_rows  <= '0;
			closing       <= 1'b0;
			o_done        <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (o_dma_rd_en) begin
				rd_beat       <= word_end ? 2'd0 : rd_beat + 2'd1;
				o_dma_rd_addr <= o_dma_rd_addr + 1'b1;
			end
			if (o_bank_filled)
				closing <= 1'b0;
			case (state)
				LD_IDLE: if (i_start) begin
					state         <= LD_IMAGE;
					o_dma_rd_en   <= 1'b1;
					o_dma_rd_addr <= i_img_base;
					rd_words      <= '0;
					rd_col        <= col_mask_t'(1);
					rd_rows       <= '0;
					rd_bank_rows  <= '0;
					closing       <= 1'b0;
				end
				LD_IMAGE: if (word_end) begin
					rd_words <= rd_words + 1'b1;
					if (rd_words == i_img_words - 1'b1) begin
						state         <= LD_WEIGHT;
						o_dma_rd_addr <= i_wgt_base;
						o_dma_rd_en   <= i_can_fill;
					end
				end
				LD_WEIGHT: begin
					if (!o_dma_rd_en) begin
						o_dma_rd_en <= i_can_fill && !closing; // waiting at a row start
					end else if (word_end) begin
						rd_col <= (rd_col == last_col) ? col_mask_t'(1) : rd_col << 1;
						if (row_end) begin
							rd_rows <= rd_rows + 1'b1;
							if (rd_rows == i_wgt_rows - 1'b1) begin
								state       <= LD_DRAIN;
								o_dma_rd_en <= 1'b0;
							end else if (rd_bank_rows == wgt_count_t'(BANK_ROWS - 1)) begin
								closing      <= 1'b1;
								rd_bank_rows <= '0;
								o_dma_rd_en  <= 1'b0;
							end else begin
								rd_bank_rows <= rd_bank_rows + 1'b1;
								o_dma_rd_en  <= i_can_fill;
							end
						end
					end
				end
				LD_DRAIN: if (wr_rows == i_wgt_rows && i_drained) begin
					o_done <= 1'b1;
					state  <= LD_IDLE;
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	// read data comes back one cycle after the request
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst)
			beat_vld <= 1'b0;
		else
			beat_vld <= o_dma_rd_en;
	end

	beat_packer u_beat_packer (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_beat_vld (beat_vld),
		.i_beat     (i_dma_rd_data),
		.o_word_vld (word_vld),
		.o_word     (word)
	);

	assign img_sel        = wr_words != i_img_words; // image words come first
	assign o_img_wr_en    = word_vld && img_sel;
	assign o_img_wr_addr  = wr_words;
	assign o_img_wr_data  = word;
	assign o_wmem_wr_en   = (word_vld && !img_sel) ? wr_col : '0;
	assign o_wmem_wr_addr = wr_addr;
	assign o_wmem_wr_data = word;
	assign wr_row_end     = word_vld && !img_sel && (wr_col == last_col);
	assign o_bank_filled  = wr_row_end && (wr_addr == wmem_addr_t'(BANK_ROWS - 1) ||
		wr_rows == i_wgt_rows - 1'b1);
	assign o_fill_rows    = wgt_count_t'(wr_addr) + 1'b1;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_words <= '0;
			wr_col   <= col_mask_t'(1);
			wr_addr  <= '0;
			wr_rows  <= '0;
		end else if (state == LD_IDLE && i_start) begin
			wr_words <= '0;
			wr_col   <= col_mask_t'(1);
			wr_addr  <= '0;
			wr_rows  <= '0;
		end else if (o_img_wr_en) begin
			wr_words <= wr_words + 1'b1;
		end else if (wr_row_end) begin
			wr_col  <= col_mask_t'(1);
			wr_rows <= wr_rows + 1'b1;
			wr_addr <= o_bank_filled ? '0 : wr_addr + 1'b1;
		end else if (|o_wmem_wr_en) begin
			wr_col <= wr_col << 1;
		end
	end

	a_one_buffer: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(o_img_wr_en && (|o_wmem_wr_en)));

endmodule

// File: src/wgt_bank_ctrl.sv
// weight bank control: ping-pong full flags, fill and read pointers, rows per bank
module wgt_bank_ctrl (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_bank_filled,
	input  cnn_geom_pkg::wgt_count_t i_fill_rows,
	input  logic                     i_release,
	output logic                     o_can_fill,
	output logic                     o_fill_bank,
	output logic                     o_rd_ready,
	output logic                     o_rd_bank,
	output cnn_geom_pkg::wgt_count_t o_rd_rows,
	output logic                     o_drained,
	output logic [1:0]               o_bank_state
);
	import cnn_geom_pkg::*;

	logic [1:0] full;
	logic       fill_ptr;
	logic       rd_ptr;
	wgt_count_t rows [2];

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			full     <= 2'b00;
			fill_ptr <= 1'b0;
			rd_ptr   <= 1'b0;
		end else begin
			if (i_bank_filled) begin
				full[fill_ptr] <= 1'b1;
				fill_ptr       <= !fill_ptr;
			end
			if (i_release) begin // never the bank being filled
				full[rd_ptr] <= 1'b0;
				rd_ptr       <= !rd_ptr;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_bank_filled)
			rows[fill_ptr] <= i_fill_rows;
	end

	assign o_can_fill   = !full[fill_ptr];
	assign o_fill_bank  = fill_ptr;
	assign o_rd_ready   = full[rd_ptr];
	assign o_rd_bank    = rd_ptr;
	assign o_rd_rows    = rows[rd_ptr];
	assign o_drained    = !(|full);
	assign o_bank_state = full;

	a_fill_empty: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_bank_filled |-> !full[fill_ptr]);

	a_release_full: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_release |-> full[rd_ptr]);

endmodule

// File: src/wgt_read_seq.sv
// weight read sequencer: update strobe, read address walk and bank release
module wgt_read_seq (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_rd_ready,
	input  cnn_geom_pkg::wgt_count_t i_rd_rows,
	input  logic                     i_rd_step,
	output logic                     o_update_wgt,
	output cnn_geom_pkg::wmem_addr_t o_wmem_rd_addr,
	output logic                     o_rd_bank_out,
	output logic                     o_release
);
	import cnn_geom_pkg::*;

	logic       active; // a bank is held by the compute array
	wgt_count_t last_addr;

	assign last_addr = i_rd_rows - wgt_count_t'(1);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active         <= 1'b0;
			o_update_wgt   <= 1'b0;
			o_wmem_rd_addr <= '0;
			o_rd_bank_out  <= 1'b0;
			o_release      <= 1'b0;
		end else begin
			o_update_wgt <= 1'b0;
			o_release    <= 1'b0;
			if (o_release) begin
				// bank flag clears on this same edge
				active        <= 1'b0;
				o_rd_bank_out <= !o_rd_bank_out;
			end else if (!active) begin
				if (i_rd_ready) begin
					active         <= 1'b1;
					o_update_wgt   <= 1'b1;
					o_wmem_rd_addr <= '0;
				end
			end else if (i_rd_step) begin
				if (wgt_count_t'(o_wmem_rd_addr) == last_addr) begin
					o_release      <= 1'b1; // last row read
					o_wmem_rd_addr <= '0;
				end else begin
					o_wmem_rd_addr <= o_wmem_rd_addr + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/cnn_loader_top.sv
// loader top: load sequencer, weight bank control and weight read sequencer
module cnn_loader_top #(
	parameter int BANK_ROWS = 128
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_start,
	input  cnn_ctrl_pkg::kernel_mode_t i_mode,
	input  cnn_geom_pkg::imem_addr_t   i_img_words,
	input  cnn_geom_pkg::wgt_count_t   i_wgt_rows,
	input  cnn_geom_pkg::dma_addr_t    i_img_base,
	input  cnn_geom_pkg::dma_addr_t    i_wgt_base,
	input  cnn_geom_pkg::beat_t        i_dma_rd_data,
	input  logic                       i_rd_step,
	output logic                       o_dma_rd_en,
	output cnn_geom_pkg::dma_addr_t    o_dma_rd_addr,
	output logic                       o_img_wr_en,
	output cnn_geom_pkg::imem_addr_t   o_img_wr_addr,
	output cnn_geom_pkg::buf_word_t    o_img_wr_data,
	output cnn_geom_pkg::col_mask_t    o_wmem_wr_en,
	output cnn_geom_pkg::wmem_addr_t   o_wmem_wr_addr,
	output cnn_geom_pkg::buf_word_t    o_wmem_wr_data,
	output logic                       o_update_wgt,
	output cnn_geom_pkg::wmem_addr_t   o_wmem_rd_addr,
	output logic                       o_rd_bank,
	output logic                       o_done,
	output logic [1:0]                 o_bank_state
);
	import cnn_geom_pkg::*;

	logic       bank_filled;
	wgt_count_t fill_rows;
	logic       can_fill;
	logic       fill_bank;
	logic       drained;
	logic       rd_ready;
	logic       buf_rd_bank; // read pointer inside the bank control
	wgt_count_t rd_rows;
	logic       release_bank;

	load_sequencer #(
		.BANK_ROWS (BANK_ROWS)
	) u_load_sequencer (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_mode         (i_mode),
		.i_img_words    (i_img_words),
		.i_wgt_rows     (i_wgt_rows),
		.i_img_base     (i_img_base),
		.i_wgt_base     (i_wgt_base),
		.i_dma_rd_data  (i_dma_rd_data),
		.i_can_fill     (can_fill),
		.i_drained      (drained),
		.o_dma_rd_en    (o_dma_rd_en),
		.o_dma_rd_addr  (o_dma_rd_addr),
		.o_img_wr_en    (o_img_wr_en),
		.o_img_wr_addr  (o_img_wr_addr),
		.o_img_wr_data  (o_img_wr_data),
		.o_wmem_wr_en   (o_wmem_wr_en),
		.o_wmem_wr_addr (o_wmem_wr_addr),
		.o_wmem_wr_data (o_wmem_wr_data),
		.o_bank_filled  (bank_filled),
		.o_fill_rows    (fill_rows),
		.o_done         (o_done)
	);

	wgt_bank_ctrl u_wgt_bank_ctrl (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_bank_filled (bank_filled),
		.i_fill_rows   (fill_rows),
		.i_release     (release_bank),
		.o_can_fill    (can_fill),
		.o_fill_bank   (fill_bank),
		.o_rd_ready    (rd_ready),
		.o_rd_bank     (buf_rd_bank),
		.o_rd_rows     (rd_rows),
		.o_drained     (drained),
		.o_bank_state  (o_bank_state)
	);

	wgt_read_seq u_wgt_read_seq (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_rd_ready     (rd_ready),
		.i_rd_rows      (rd_rows),
		.i_rd_step      (i_rd_step),
		.o_update_wgt   (o_update_wgt),
		.o_wmem_rd_addr (o_wmem_rd_addr),
		.o_rd_bank_out  (o_rd_bank),
		.o_release      (release_bank)
	);

	// consumer and buffer agree on which bank is being read
	a_rd_bank_match: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_update_wgt |-> (o_rd_bank == buf_rd_bank));

	// filling never targets the bank the consumer holds
	a_fill_not_read: assert property (@(posedge i_clk) disable iff (!i_rst)
		(bank_filled && rd_ready) |-> (fill_bank != buf_rd_bank));

endmodule

// File: sim/tb_model.svh
// LFSR stimulus source, DMA memory image, expected write data and typed compare tasks

logic [15:0] lfsr = 16'd9506;
beat_t       dma_mem [4096];
int          err_cnt = 0;

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic        fb;
	int          i;
	v = '0;
	for (i = 0; i < n; i++) begin
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		v    = {v[30:0], fb};
	end
	return v;
endfunction

// columns per weight row
function automatic int cols_for_mode(input kernel_mode_t mode);
	case (mode)
		MODE_4X4: return 4;
		MODE_5X5: return 5;
		default:  return 6;
	endcase
endfunction

// word k of a block at base, lowest address in the low bits
function automatic buf_word_t expected_word(input dma_addr_t base, input int k);
	dma_addr_t a0;
	dma_addr_t a1;
	dma_addr_t a2;
	a0 = base + dma_addr_t'(3 * k); // wraps like the DMA address counter
	a1 = a0 + dma_addr_t'(1);
	a2 = a0 + dma_addr_t'(2);
	return {dma_mem[a2], dma_mem[a1], dma_mem[a0]};
endfunction

task automatic compare_word(input string what, input buf_word_t got, input buf_word_t exp);
	if (got !== exp) begin
		err_cnt++;
		$display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic compare_img_addr(input string what, input imem_addr_t got, input imem_addr_t exp);
	if (got !== exp) begin
		err_cnt++;
		$display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic compare_wmem_addr(input string what, input wmem_addr_t got, input wmem_addr_t exp);
	if (got !== exp) begin
		err_cnt++;
		$display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic compare_mask(input string what, input col_mask_t got, input col_mask_t exp);
	if (got !== exp) begin
		err_cnt++;
		$display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic compare_count(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		err_cnt++;
		$display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

// File: sim/tb_cnn_loader.sv
// testbench for the loader: clock, reset, random runs, DMA memory, monitor and watchdog
module tb_cnn_loader;
	import cnn_geom_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int BANK_ROWS = 8;
	localparam int NUM_RUNS  = 8;

	logic         i_clk = 1'b0;
	logic         i_rst;
	logic         i_start;
	kernel_mode_t i_mode;
	imem_addr_t   i_img_words;
	wgt_count_t   i_wgt_rows;
	dma_addr_t    i_img_base;
	dma_addr_t    i_wgt_base;
	beat_t        i_dma_rd_data;
	logic         i_rd_step;
	logic         o_dma_rd_en;
	dma_addr_t    o_dma_rd_addr;
	logic         o_img_wr_en;
	imem_addr_t   o_img_wr_addr;
	buf_word_t    o_img_wr_data;
	col_mask_t    o_wmem_wr_en;
	wmem_addr_t   o_wmem_wr_addr;
	buf_word_t    o_wmem_wr_data;
	logic         o_update_wgt;
	wmem_addr_t   o_wmem_rd_addr;
	logic         o_rd_bank;
	logic         o_done;
	logic [1:0]   o_bank_state;

	`include "tb_model.svh"

	kernel_mode_t run_mode [NUM_RUNS];
	int           run_img [NUM_RUNS];
	int           run_rows [NUM_RUNS];
	dma_addr_t    run_ibase [NUM_RUNS];
	dma_addr_t    run_wbase [NUM_RUNS];

	int        cur_img;
	int        cur_rows;
	int        cur_c;
	dma_addr_t cur_ibase;
	dma_addr_t cur_wbase;
	int        img_cnt;
	int        wgt_cnt;
	int        rd_cnt;
	int        upd_cnt;
	int        done_cnt;
	int        upd_total = 0; // updates since reset, banks alternate from bank 0
	int        exp_rd = 0;    // expected consumer read address
	int        bank_rows = 0; // rows in the bank being read
	logic      holding = 1'b0;
	logic      stall_rd = 1'b0; // consumer held off until both banks fill
	logic      prev_rd_en = 1'b0;
	int        limit_cycles = 0;
	int        num_tests = 0;
	int        fail_tests = 0;

	cnn_loader_top #(
		.BANK_ROWS (BANK_ROWS)
	) u_cnn_loader_top (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_mode         (i_mode),
		.i_img_words    (i_img_words),
		.i_wgt_rows     (i_wgt_rows),
		.i_img_base     (i_img_base),
		.i_wgt_base     (i_wgt_base),
		.i_dma_rd_data  (i_dma_rd_data),
		.i_rd_step      (i_rd_step),
		.o_dma_rd_en    (o_dma_rd_en),
		.o_dma_rd_addr  (o_dma_rd_addr),
		.o_img_wr_en    (o_img_wr_en),
		.o_img_wr_addr  (o_img_wr_addr),
		.o_img_wr_data  (o_img_wr_data),
		.o_wmem_wr_en   (o_wmem_wr_en),
		.o_wmem_wr_addr (o_wmem_wr_addr),
		.o_wmem_wr_data (o_wmem_wr_data),
		.o_update_wgt   (o_update_wgt),
		.o_wmem_rd_addr (o_wmem_rd_addr),
		.o_rd_bank      (o_rd_bank),
		.o_done         (o_done),
		.o_bank_state   (o_bank_state)
	);

	always #4 i_clk = ~i_clk;

	// DMA answers one cycle after the read
	always @(posedge i_clk) begin
		if (o_dma_rd_en)
			i_dma_rd_data <= dma_mem[o_dma_rd_addr];
	end

	// monitor, sampled mid-cycle
	always @(negedge i_clk) begin
		if (i_rst) begin
			if (o_img_wr_en) begin
				compare_img_addr("image address", o_img_wr_addr, imem_addr_t'(img_cnt));
				compare_word("image data", o_img_wr_data, expected_word(cur_ibase, img_cnt));
				img_cnt++;
			end
			if (|o_wmem_wr_en) begin
				compare_mask("weight column", o_wmem_wr_en, col_mask_t'(1) << (wgt_cnt % cur_c));
				compare_wmem_addr("weight address", o_wmem_wr_addr,
					wmem_addr_t'((wgt_cnt / cur_c) % BANK_ROWS));
				compare_word("weight data", o_wmem_wr_data, expected_word(cur_wbase, wgt_cnt));
				wgt_cnt++;
			end
			if (o_bank_state == 2'b11 || wgt_cnt == cur_rows * cur_c)
				stall_rd = 1'b0;
			if (o_dma_rd_en && !prev_rd_en && o_bank_state == 2'b11) begin
				err_cnt++;
				$display("error at time %0t: DMA read started with both banks full", $time);
			end
			if (o_dma_rd_en)
				rd_cnt++;
			prev_rd_en = o_dma_rd_en;
			compare_wmem_addr("read address", o_wmem_rd_addr, wmem_addr_t'(exp_rd));
			if (o_update_wgt) begin
				compare_count("read bank", o_rd_bank, upd_total % 2);
				upd_total++;
				bank_rows = cur_rows - upd_cnt * BANK_ROWS;
				if (bank_rows > BANK_ROWS)
					bank_rows = BANK_ROWS;
				holding = 1'b1;
				exp_rd  = 0;
				upd_cnt++;
			end
			// a step seen now moves the address on the next edge
			if (holding && i_rd_step) begin
				if (exp_rd == bank_rows - 1) begin
					exp_rd  = 0;
					holding = 1'b0;
				end else begin
					exp_rd++;
				end
			end
			if (o_done) begin
				done_cnt++;
				compare_count("weight writes at done", wgt_cnt, cur_rows * cur_c);
				compare_count("bank state at done", o_bank_state, 0);
			end
		end
	end

	task automatic report_test(input string name, input int errs);
		num_tests++;
		if (errs == 0) begin
			$display("%s: pass", name);
		end else begin
			fail_tests++;
			$display("%s: FAIL with %0d errors", name, errs);
		end
	endtask

	initial begin
		int a;
		int r;
		int mode_ofs;
		int total_beats;
		int first;
		i_rst         = 1'b0;
		i_start       = 1'b0;
		i_mode        = MODE_3X3_QUAD;
		i_img_words   = '0;
		i_wgt_rows    = '0;
		i_img_base    = '0;
		i_wgt_base    = '0;
		i_dma_rd_data = '0;
		i_rd_step     = 1'b0;
		for (a = 0; a < 4096; a++)
			dma_mem[a] = beat_t'(rand_bits(16));
		mode_ofs    = rand_bits(2);
		total_beats = 0;
		for (r = 0; r < NUM_RUNS; r++) begin
			run_mode[r] = kernel_mode_t'((r + mode_ofs) % 4); // each mode twice
			run_img[r]  = 4 + rand_bits(5) % 17;
			if (r % 2 == 1)
				run_rows[r] = 17 + rand_bits(5) % 14; // three banks or more
			else
				run_rows[r] = 1 + rand_bits(5) % 30;
			run_ibase[r] = dma_addr_t'(rand_bits(12));
			run_wbase[r] = dma_addr_t'(rand_bits(12));
			total_beats += 3 * (run_img[r] + run_rows[r] * cols_for_mode(run_mode[r]));
		end
		limit_cycles = 20 * total_beats;

		repeat (10) @(posedge i_clk);
		i_rst <= 1'b1;
		@(negedge i_clk);
		first = err_cnt;
		compare_count("control outputs after reset",
			{o_dma_rd_en, o_img_wr_en, o_update_wgt, o_done}, 0);
		compare_mask("weight write enable after reset", o_wmem_wr_en, '0);
		compare_count("bank state after reset", o_bank_state, 0);
		compare_wmem_addr("read address after reset", o_wmem_rd_addr, '0);
		compare_count("read bank after reset", o_rd_bank, 0);
		report_test("reset values", err_cnt - first);

		for (r = 0; r < NUM_RUNS; r++) begin
			@(posedge i_clk);
			first     = err_cnt;
			cur_img   = run_img[r];
			cur_rows  = run_rows[r];
			cur_c     = cols_for_mode(run_mode[r]);
			cur_ibase = run_ibase[r];
			cur_wbase = run_wbase[r];
			img_cnt   = 0;
			wgt_cnt   = 0;
			rd_cnt    = 0;
			upd_cnt   = 0;
			done_cnt  = 0;
			stall_rd  = (r % 2 == 1);
			i_mode      <= run_mode[r];
			i_img_words <= imem_addr_t'(cur_img);
			i_wgt_rows  <= wgt_count_t'(cur_rows);
			i_img_base  <= cur_ibase;
			i_wgt_base  <= cur_wbase;
			i_start     <= 1'b1;
			@(posedge i_clk);
			i_start <= 1'b0;
			while (done_cnt == 0) begin
				@(posedge i_clk);
				if (stall_rd)
					i_rd_step <= 1'b0;
				else
					i_rd_step <= rand_bits(1);
			end
			@(posedge i_clk);
			i_rd_step <= 1'b0;
			repeat (4) @(posedge i_clk); // room for a stray second done
			compare_count("image writes", img_cnt, cur_img);
			compare_count("weight writes", wgt_cnt, cur_rows * cur_c);
			compare_count("DMA reads", rd_cnt, 3 * (cur_img + cur_rows * cur_c));
			compare_count("weight updates", upd_cnt, (cur_rows + BANK_ROWS - 1) / BANK_ROWS);
			compare_count("done pulses", done_cnt, 1);
			report_test($sformatf("run %0d mode %0d, %0d image words, %0d weight rows",
				r, run_mode[r], cur_img, cur_rows), err_cnt - first);
		end

		$display("%0d tests, %0d failed, %0d errors", num_tests, fail_tests, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the beats of all runs
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles + 10) @(posedge i_clk);
		$display("timeout: loader did not finish within %0d cycles", limit_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: sim.f
+incdir+sim
src/cnn_geom_pkg.sv
src/cnn_ctrl_pkg.sv
src/beat_packer.sv
src/load_sequencer.sv
src/wgt_bank_ctrl.sv
src/wgt_read_seq.sv
src/cnn_loader_top.sv
sim/tb_cnn_loader.sv
